/* logic/audio_params.svh */
//--------------------------------------------------
// Audio engine constants
// Address map, memory sizes and I2S clock divider
//--------------------------------------------------

`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Region select, compared against addr[31:16]
`define AE_BASE        16'h6000
`define AE_OFS_COEF    16'h0000
`define AE_OFS_RESULT  16'h0100
`define AE_OFS_STATUS  16'h0200
`define AE_OFS_RESET   16'h0300
`define AE_OFS_INPUT   16'h0400

`define AE_CHANNELS    2
`define AE_FRAMES      64
`define AE_CODE        64
`define AE_FRAME_W     $clog2(`AE_FRAMES)
`define AE_CODE_W      $clog2(`AE_CODE)
`define AE_AUDIO_W     $clog2(`AE_CHANNELS * `AE_FRAMES)

// ck cycles per sck period
`define AE_I2S_DIVIDER 6

`endif

/* logic/audio_pkg.sv */
//--------------------------------------------------
// Audio engine types
// Bus, RAM write, I2S timing and program words
//--------------------------------------------------

`include "audio_params.svh"

package audio_pkg;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                   en;
        logic [`AE_AUDIO_W-1:0] addr;
        logic [15:0]            data;
    } ram_wr_t;

    // en is a one-cycle strobe at each sck falling edge
    typedef struct packed {
        logic       en;
        logic       ws;
        logic [5:0] frame_posn;
    } i2s_timing_t;

    typedef struct packed {
        logic        we;
        logic        sel;
        logic [15:0] sample;
    } seq_out_t;

    typedef enum logic [1:0] {
        OP_HALT = 2'd0,
        OP_MAC  = 2'd1,
        OP_OUT  = 2'd2
    } op_e;

    typedef struct packed {
        op_e                op;
        logic               chan;
        logic [5:0]         offset;
        logic [6:0]         spare;
        logic signed [15:0] gain;
    } mac_instr_t;

    typedef struct packed {
        op_e         op;
        logic        sel;
        logic [28:0] spare;
    } out_instr_t;

    // Both views share the op field in the top two bits
    typedef union packed {
        mac_instr_t mac;
        out_instr_t out;
    } coef_word_u;

endpackage

/* logic/dpram.sv */
//--------------------------------------------------
// Dual-port RAM
// One write port, one read port with registered data
//--------------------------------------------------

`timescale 1ns/1ps

module dpram #(
    parameter int BITS = 16,
    parameter int SIZE = 128
) (
    input  logic                    ck,
    input  logic                    we,
    input  logic [$clog2(SIZE)-1:0] waddr,
    input  logic [BITS-1:0]         wdata,
    input  logic [$clog2(SIZE)-1:0] raddr,
    output logic [BITS-1:0]         rdata
);

    logic [BITS-1:0] mem [SIZE];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* logic/i2s_clock.sv */
//--------------------------------------------------
// I2S clock generator
// Makes sck, ws, the bit strobe and frame position
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module i2s_clock (
    input  logic                   ck,
    input  logic                   rst_n,
    output logic                   sck,
    output audio_pkg::i2s_timing_t timing
);

    localparam int DW = $clog2(`AE_I2S_DIVIDER);
    localparam logic [DW-1:0] DIV_LAST = DW'(`AE_I2S_DIVIDER - 1);
    localparam logic [DW-1:0] DIV_HALF = DW'(`AE_I2S_DIVIDER / 2 - 1);

    logic [DW-1:0] div;
    logic [5:0]    next_posn;

    assign next_posn = timing.frame_posn + 6'd1;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            div <= '0;
            sck <= 1'b0;
            timing <= '0;
        end else begin
            timing.en <= 1'b0;
            if (div == DIV_LAST) begin
                // Falling edge, the next bit period starts here
                div <= '0;
                sck <= 1'b0;
                timing.en <= 1'b1;
                timing.frame_posn <= next_posn;
                timing.ws <= next_posn[5];
            end else begin
                div <= div + 1'b1;
                if (div == DIV_HALF) begin
                    sck <= 1'b1;
                end
            end
        end
    end

    a_en_single: assert property (@(posedge ck) disable iff (!rst_n)
        timing.en |=> !timing.en);

endmodule

/* logic/i2s_rx.sv */
//--------------------------------------------------
// I2S receiver
// Shifts in one stereo line, keeps the last samples
//--------------------------------------------------

`timescale 1ns/1ps

module i2s_rx (
    input  logic                   ck,
    input  logic                   rst_n,
    input  audio_pkg::i2s_timing_t timing,
    input  logic                   sd,
    output logic [15:0]            left,
    output logic [15:0]            right
);

    logic [15:0] shift;
    logic [15:0] shift_next;

    // sd still holds the bit of the period that just ended
    assign shift_next = {shift[14:0], sd};

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            left <= '0;
            right <= '0;
        end else if (timing.en) begin
            if (timing.frame_posn == 6'd17) begin
                left <= shift_next;
            end
            if (timing.frame_posn == 6'd49) begin
                right <= shift_next;
            end
        end
    end

    always_ff @(posedge ck) begin
        if (timing.en) begin
            shift <= shift_next;
        end
    end

endmodule

/* logic/i2s_tx.sv */
//--------------------------------------------------
// I2S transmitter
// Sends left and right samples MSB first on sd
//--------------------------------------------------

`timescale 1ns/1ps

module i2s_tx (
    input  logic                   ck,
    input  logic                   rst_n,
    input  audio_pkg::i2s_timing_t timing,
    input  logic [15:0]            left,
    input  logic [15:0]            right,
    output logic                   sd
);

    logic [15:0] shift;
    logic [4:0]  slot;
    logic        in_window;

    // Position inside the current half frame
    assign slot = timing.frame_posn[4:0];
    assign in_window = (slot >= 5'd1) && (slot <= 5'd16);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            sd <= 1'b0;
            shift <= '0;
        end else if (timing.en) begin
            sd <= in_window ? shift[15] : 1'b0;
            if (slot == 5'd0) begin
                shift <= timing.ws ? right : left;
            end else begin
                shift <= {shift[14:0], 1'b0};
            end
        end
    end

endmodule

/* logic/frame_capture.sv */
//--------------------------------------------------
// Frame capture
// Stores each received frame and requests a run
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module frame_capture (
    input  logic                   ck,
    input  logic                   rst_n,
    input  audio_pkg::i2s_timing_t timing,
    input  logic [15:0]            mic_left,
    input  logic [15:0]            mic_right,
    input  logic                   hold,
    output audio_pkg::ram_wr_t     wr,
    output logic [`AE_FRAME_W-1:0] frame_count,
    output logic                   start
);

    // 0 idle, 1 write chan 0, 2 write chan 1, 3 start
    logic [1:0] phase;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            phase <= 2'd0;
            frame_count <= '0;
        end else if (phase != 2'd0) begin
            // Host-load mode cancels a capture in progress
            phase <= hold ? 2'd0 : phase + 2'd1;
        end else if (timing.en && (timing.frame_posn == 6'd0) && !hold) begin
            phase <= 2'd1;
            frame_count <= frame_count - 1'b1;
        end
    end

    assign wr.en = (phase == 2'd1) || (phase == 2'd2);
    assign wr.addr = {phase == 2'd2, frame_count};
    assign wr.data = (phase == 2'd2) ? mic_right : mic_left;
    assign start = phase == 2'd3;

    // Both channel writes land before the run is requested
    a_start_after_writes: assert property (@(posedge ck) disable iff (!rst_n)
        start |-> !wr.en && $past(wr.en) && $past(wr.en, 2));

endmodule

/* logic/sequencer.sv */
//--------------------------------------------------
// Program sequencer
// Runs the MAC/OUT/HALT program over the audio RAM
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module sequencer (
    input  logic                   ck,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`AE_FRAME_W-1:0] frame,
    output logic [`AE_CODE_W-1:0]  coef_addr,
    input  logic [31:0]            coef_data,
    output logic [`AE_AUDIO_W-1:0] audio_addr,
    input  logic [15:0]            audio_data,
    output audio_pkg::seq_out_t    result,
    output logic                   done,
    output logic                   error
);

    import audio_pkg::*;

    localparam int CW = `AE_CODE_W;
    localparam logic [CW-1:0] PC_LAST = CW'(`AE_CODE - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_AUDIO_WAIT,
        S_ACCUM
    } state_e;

    state_e                 state;
    coef_word_u             word;
    logic [CW-1:0]          pc;
    logic [`AE_FRAME_W-1:0] frame_r;
    logic signed [15:0]     gain_r;
    logic signed [15:0]     sample;
    logic signed [39:0]     acc;
    logic signed [39:0]     shifted;
    logic [15:0]            sat;
    logic                   advance;

    assign word = coef_data;
    assign sample = audio_data;
    assign coef_addr = pc;

    // Unknown op codes fall through as no-ops
    assign advance = (state == S_ACCUM) ||
                     ((state == S_DECODE) && (word.mac.op != OP_MAC) &&
                      (word.mac.op != OP_HALT));

    // Q15 scaling with saturation to 16 bits
    assign shifted = acc >>> 15;
    assign sat = (shifted[39:15] == {25{shifted[15]}}) ? shifted[15:0] :
                 (shifted[39] ? 16'h8000 : 16'h7fff);

    assign result.we = (state == S_DECODE) && (word.out.op == OP_OUT);
    assign result.sel = word.out.sel;
    assign result.sample = sat;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc <= '0;
            acc <= '0;
            done <= 1'b0;
            error <= 1'b0;
        end else if (start) begin
            state <= S_FETCH;
            pc <= '0;
            acc <= '0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                S_FETCH: state <= S_DECODE;
                S_DECODE: begin
                    if (word.mac.op == OP_HALT) begin
                        done <= 1'b1;
                        state <= S_IDLE;
                    end else if (word.mac.op == OP_MAC) begin
                        state <= S_AUDIO_WAIT;
                    end else if (word.out.op == OP_OUT) begin
                        acc <= '0;
                    end
                end
                S_AUDIO_WAIT: state <= S_ACCUM;
                S_ACCUM: acc <= acc + sample * gain_r;
                default: state <= S_IDLE;
            endcase
            if (advance) begin
                if (pc == PC_LAST) begin
                    // Ran off the end of the program
                    done <= 1'b1;
                    error <= 1'b1;
                    state <= S_IDLE;
                end else begin
                    pc <= pc + 1'b1;
                    state <= S_FETCH;
                end
            end
        end
    end

    always_ff @(posedge ck) begin
        if (start) begin
            frame_r <= frame;
        end
        if (state == S_DECODE) begin
            audio_addr <= {word.mac.chan, frame_r - word.mac.offset};
            gain_r <= word.mac.gain;
        end
    end

    a_no_out_idle: assert property (@(posedge ck) disable iff (!rst_n)
        (state == S_IDLE) |-> !result.we);

endmodule

/* logic/host_regs.sv */
//--------------------------------------------------
// Host bus registers
// Region decode, control, run request and outputs
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module host_regs (
    input  logic                   ck,
    input  logic                   rst_n,
    input  audio_pkg::bus_req_t    bus,
    output logic                   ready,
    output logic [31:0]            rdata,
    output logic                   coef_we,
    input  audio_pkg::ram_wr_t     cap_wr,
    output audio_pkg::ram_wr_t     audio_wr,
    output logic                   hold,
    output logic [`AE_FRAME_W-1:0] host_frame,
    output logic                   run_req,
    input  audio_pkg::seq_out_t    seq_result,
    input  logic                   done,
    input  logic                   error,
    input  logic [`AE_FRAME_W-1:0] frame_count,
    output logic [15:0]            left,
    output logic [15:0]            right
);

    logic [15:0]            region;
    logic                   hit_coef;
    logic                   hit_result;
    logic                   hit_status;
    logic                   hit_reset;
    logic                   hit_input;
    logic                   go;
    logic [`AE_FRAME_W:0]   ctrl;

    assign region = bus.addr[31:16];
    assign hit_coef = region == (`AE_BASE + `AE_OFS_COEF);
    assign hit_result = region == (`AE_BASE + `AE_OFS_RESULT);
    assign hit_status = region == (`AE_BASE + `AE_OFS_STATUS);
    assign hit_reset = region == (`AE_BASE + `AE_OFS_RESET);
    assign hit_input = region == (`AE_BASE + `AE_OFS_INPUT);

    // One accepted access per request, blocked during the ready cycle
    assign go = bus.valid && !ready &&
                (hit_coef || hit_result || hit_status || hit_reset || hit_input);

    assign coef_we = go && hit_coef;
    assign hold = ctrl[0];
    // Run frame follows the host frame in host-load mode
    assign host_frame = hold ? ctrl[`AE_FRAME_W:1] : frame_count;

    always_comb begin
        if (hold) begin
            audio_wr.en = go && hit_input;
            audio_wr.addr = bus.addr[`AE_AUDIO_W+1:2];
            audio_wr.data = bus.wdata[15:0];
        end else begin
            audio_wr = cap_wr;
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            ready <= 1'b0;
            rdata <= '0;
            ctrl <= '0;
            run_req <= 1'b0;
            left <= '0;
            right <= '0;
        end else begin
            ready <= go;
            run_req <= go && hit_reset;
            rdata <= '0;
            if (go && hit_result) begin
                rdata <= {16'h0, bus.addr[2] ? right : left};
            end
            // Any access at STATUS+0 loads the control register from wdata
            if (go && hit_status) begin
                if (bus.addr[2]) begin
                    rdata <= 32'(frame_count);
                end else begin
                    rdata <= {30'h0, error, done};
                    ctrl <= bus.wdata[`AE_FRAME_W:0];
                end
            end
            if (seq_result.we) begin
                if (seq_result.sel) begin
                    right <= seq_result.sample;
                end else begin
                    left <= seq_result.sample;
                end
            end
        end
    end

endmodule

/* logic/audio_engine.sv */
//--------------------------------------------------
// Audio engine top level
// I2S, capture, sequencer, bus registers and RAMs
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module audio_engine (
    input  logic                ck,
    input  logic                rst_n,
    input  audio_pkg::bus_req_t bus,
    output logic                ready,
    output logic [31:0]         rdata,
    output logic                sck,
    output logic                ws,
    output logic                sd_out,
    input  logic                sd_in
);

    import audio_pkg::*;

    i2s_timing_t            timing;
    ram_wr_t                cap_wr;
    ram_wr_t                audio_wr;
    seq_out_t               seq_result;
    logic [15:0]            mic_left;
    logic [15:0]            mic_right;
    logic [15:0]            left;
    logic [15:0]            right;
    logic [`AE_FRAME_W-1:0] frame_count;
    logic [`AE_FRAME_W-1:0] run_frame;
    logic                   cap_start;
    logic                   run_req;
    logic                   hold;
    logic                   coef_we;
    logic                   done;
    logic                   error;
    logic [`AE_CODE_W-1:0]  coef_raddr;
    logic [31:0]            coef_rdata;
    logic [`AE_AUDIO_W-1:0] audio_raddr;
    logic [15:0]            audio_rdata;

    assign ws = timing.ws;

    i2s_clock i2s_clock0 (.ck(ck), .rst_n(rst_n), .sck(sck), .timing(timing));

    i2s_rx i2s_rx0 (
        .ck(ck), .rst_n(rst_n), .timing(timing), .sd(sd_in),
        .left(mic_left), .right(mic_right)
    );

    i2s_tx i2s_tx0 (
        .ck(ck), .rst_n(rst_n), .timing(timing),
        .left(left), .right(right), .sd(sd_out)
    );

    frame_capture frame_capture0 (
        .ck(ck), .rst_n(rst_n), .timing(timing),
        .mic_left(mic_left), .mic_right(mic_right), .hold(hold),
        .wr(cap_wr), .frame_count(frame_count), .start(cap_start)
    );

    sequencer sequencer0 (
        .ck(ck), .rst_n(rst_n), .start(run_req | cap_start), .frame(run_frame),
        .coef_addr(coef_raddr), .coef_data(coef_rdata),
        .audio_addr(audio_raddr), .audio_data(audio_rdata),
        .result(seq_result), .done(done), .error(error)
    );

    host_regs host_regs0 (
        .ck(ck), .rst_n(rst_n), .bus(bus), .ready(ready), .rdata(rdata),
        .coef_we(coef_we), .cap_wr(cap_wr), .audio_wr(audio_wr),
        .hold(hold), .host_frame(run_frame), .run_req(run_req),
        .seq_result(seq_result), .done(done), .error(error),
        .frame_count(frame_count), .left(left), .right(right)
    );

    // Program store, written by the host
    dpram #(.BITS(32), .SIZE(`AE_CODE)) coef_ram (
        .ck(ck), .we(coef_we), .waddr(bus.addr[`AE_CODE_W+1:2]), .wdata(bus.wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    // Samples addressed as {chan, frame}
    dpram #(.BITS(16), .SIZE(`AE_CHANNELS * `AE_FRAMES)) audio_ram (
        .ck(ck), .we(audio_wr.en), .waddr(audio_wr.addr), .wdata(audio_wr.data),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

endmodule

/* test/audio_model.svh */
//--------------------------------------------------
// Audio engine testbench model
// Program rules, Q15 scaling, I2S bit order and
// the host bus tasks
//--------------------------------------------------

`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

// Shift right by 15, then clamp to the signed 16-bit range
function automatic logic [15:0] scale_sat(input longint acc);
    longint v;
    v = acc >>> 15;
    if (v > 32767) begin
        return 16'h7fff;
    end
    if (v < -32768) begin
        return 16'h8000;
    end
    return v[15:0];
endfunction

// Bit on the line at a frame position, MSB first from positions 1 and 33
function automatic logic i2s_bit(input logic [15:0] l, input logic [15:0] r, input int posn);
    if (posn >= 1 && posn <= 16) begin
        return l[16 - posn];
    end
    if (posn >= 33 && posn <= 48) begin
        return r[48 - posn];
    end
    return 1'b0;
endfunction

// Runs prog over audio_mem; OUT words update model_left and model_right
task automatic run_model(input logic [5:0] frame, output logic halted);
    longint      acc;
    logic [31:0] w;
    logic [5:0]  slot;
    int          pc;
    acc = 0;
    halted = 1'b0;
    pc = 0;
    while (pc < `AE_CODE && !halted) begin
        w = prog[pc];
        case (w[31:30])
            2'd0: halted = 1'b1;
            2'd1: begin
                // Sample taken offset frames back, wrapping at 64
                slot = frame - w[28:23];
                acc = acc + longint'($signed(audio_mem[{w[29], slot}])) *
                            longint'($signed(w[15:0]));
            end
            2'd2: begin
                if (w[29]) begin
                    model_right = scale_sat(acc);
                end else begin
                    model_left = scale_sat(acc);
                end
                acc = 0;
            end
            default: ;
        endcase
        pc++;
    end
endtask

function automatic logic [31:0] reg_addr(input logic [15:0] region, input int index);
    return {16'(`AE_BASE + region), 16'(index * 4)};
endfunction

// One falling edge, with edge detection on sck and ws
task automatic tick();
    @(negedge ck);
    sck_rose = sck && !sck_q;
    ws_fell = ws_q && !ws;
    if (ws_fell) begin
        frame_starts++;
    end
    sck_q = sck;
    ws_q = ws;
endtask

task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] data);
    int n;
    tick();
    bus.valid = 1'b1;
    bus.addr = addr;
    bus.wdata = wdata;
    n = 0;
    tick();
    while (!ready && n < BUS_TIMEOUT) begin
        tick();
        n++;
    end
    data = rdata;
    assert (ready) else begin
        $display("ERROR: %s: bus access at %h never got ready", test_name, addr);
        errors++;
    end
    bus = '0;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(addr, data, unused);
endtask

// Status accesses also load the control register, so reads carry its value
task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, ctrl_shadow, data);
endtask

`endif

/* test/tb_audio_engine.sv */
//--------------------------------------------------
// Audio engine testbench
// Host programs, I2S output and capture checks
//--------------------------------------------------

`timescale 1ns/1ps

`include "audio_params.svh"

module tb_audio_engine;

    import audio_pkg::*;

    localparam int BUS_TIMEOUT = 20;
    localparam int DONE_POLLS = 200;
    localparam int SCK_TIMEOUT = 2 * `AE_I2S_DIVIDER + 2;
    localparam int FRAME_TIMEOUT = 2 * 64 * `AE_I2S_DIVIDER + 16;

    logic        ck;
    logic        rst_n;
    logic        sd_in;
    bus_req_t    bus;
    logic        ready;
    logic [31:0] rdata;
    logic        sck;
    logic        ws;
    logic        sd_out;

    // Model state
    logic [15:0] audio_mem [`AE_CHANNELS * `AE_FRAMES];
    logic [31:0] prog [`AE_CODE];
    logic [15:0] model_left;
    logic [15:0] model_right;
    logic [31:0] ctrl_shadow;

    logic        sck_q;
    logic        ws_q;
    logic        sck_rose;
    logic        ws_fell;
    int          frame_starts;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int unsigned seed;
    string       test_name;

    `include "audio_model.svh"

    audio_engine dut0 (
        .ck(ck), .rst_n(rst_n), .bus(bus), .ready(ready), .rdata(rdata),
        .sck(sck), .ws(ws), .sd_out(sd_out), .sd_in(sd_in)
    );

    initial begin
        ck = 1'b0;
        forever #5 ck = ~ck;
    end

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %-14s ok", test_name);
        end else begin
            $display("test %-14s %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic wait_sck_rise();
        int n;
        n = 0;
        tick();
        while (!sck_rose && n < SCK_TIMEOUT) begin
            tick();
            n++;
        end
        assert (sck_rose) else begin
            $display("ERROR: %s: sck stopped toggling", test_name);
            errors++;
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        tick();
        while (!ws_fell && n < FRAME_TIMEOUT) begin
            tick();
            n++;
        end
        assert (ws_fell) else begin
            $display("ERROR: %s: no frame start seen on ws", test_name);
            errors++;
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int n;
        n = 0;
        bus_read(reg_addr(`AE_OFS_STATUS, 0), status);
        while (!status[0] && n < DONE_POLLS) begin
            bus_read(reg_addr(`AE_OFS_STATUS, 0), status);
            n++;
        end
        assert (status[0]) else begin
            $display("ERROR: %s: the run never signalled done", test_name);
            errors++;
        end
    endtask

    task automatic set_ctrl(input logic hold, input logic [5:0] frame);
        ctrl_shadow = {25'd0, frame, hold};
        bus_write(reg_addr(`AE_OFS_STATUS, 0), ctrl_shadow);
    endtask

    function automatic logic [31:0] mac_word(input logic chan, input logic [5:0] offset,
                                             input logic [15:0] gain);
        return {2'd1, chan, offset, 7'd0, gain};
    endfunction

    function automatic logic [31:0] out_word(input logic sel);
        return {2'd2, sel, 29'd0};
    endfunction

    // Random MAC or OUT word, big gains push the accumulator into saturation
    function automatic logic [31:0] random_word(input logic big);
        logic [31:0] value;
        logic [15:0] gain;
        value = $urandom;
        gain = value[31:16];
        if (big) begin
            gain = value[10] ? 16'h7fff : 16'h8000;
        end
        if (value[1:0] == 2'd0) begin
            return out_word(value[2]);
        end
        return mac_word(value[3], value[9:4], gain);
    endfunction

    task automatic write_program(input int count);
        for (int i = 0; i < count; i++) begin
            bus_write(reg_addr(`AE_OFS_COEF, i), prog[i]);
        end
    endtask

    // Start a host run and check status and both outputs against the model
    task automatic run_and_check(input logic [5:0] frame, input string tag);
        logic [31:0] status;
        logic [31:0] value;
        logic        halted;
        bus_write(reg_addr(`AE_OFS_RESET, 0), 32'd0);
        wait_done(status);
        run_model(frame, halted);
        compare({tag, " status"}, 64'({30'd0, !halted, 1'b1}), 64'(status));
        bus_read(reg_addr(`AE_OFS_RESULT, 0), value);
        compare({tag, " left"}, 64'(model_left), 64'(value));
        bus_read(reg_addr(`AE_OFS_RESULT, 1), value);
        compare({tag, " right"}, 64'(model_right), 64'(value));
    endtask

    task automatic test_reset_state();
        logic [31:0] value;
        begin_test("reset_state");
        compare("i2s lines", 64'd0, 64'({sck, ws, sd_out}));
        bus_read(reg_addr(`AE_OFS_STATUS, 0), value);
        compare("status", 64'd0, 64'(value));
        bus_read(reg_addr(`AE_OFS_RESULT, 0), value);
        compare("left", 64'd0, 64'(value));
        bus_read(reg_addr(`AE_OFS_RESULT, 1), value);
        compare("right", 64'd0, 64'(value));
        bus_read(reg_addr(`AE_OFS_STATUS, 1), value);
        compare("frame counter", 64'd0, 64'(value));
        end_test();
    endtask

    task automatic test_host_program();
        logic [5:0]  frame;
        logic [31:0] value;
        logic        big;
        int          len;
        begin_test("host_program");
        for (int k = 0; k < 6; k++) begin
            big = (k == 2) || (k == 5);
            frame = 6'($urandom);
            set_ctrl(1'b1, frame);
            for (int i = 0; i < `AE_CHANNELS * `AE_FRAMES; i++) begin
                value = $urandom;
                if (big) begin
                    value[15:14] = value[0] ? 2'b01 : 2'b10;
                end
                audio_mem[i] = value[15:0];
                bus_write(reg_addr(`AE_OFS_INPUT, i), value);
            end
            len = 4 + int'($urandom % 20);
            for (int i = 0; i < len; i++) begin
                prog[i] = random_word(big);
            end
            prog[len - 1] = out_word(k[0]);
            prog[len] = 32'd0;
            write_program(len + 1);
            run_and_check(frame, $sformatf("program %0d", k));
        end
        end_test();
    endtask

    task automatic test_i2s_output();
        logic [63:0] bits;
        logic [63:0] expected;
        logic [31:0] bus_left;
        logic [31:0] bus_right;
        begin_test("i2s_output");
        bus_read(reg_addr(`AE_OFS_RESULT, 0), bus_left);
        bus_read(reg_addr(`AE_OFS_RESULT, 1), bus_right);
        wait_frame_start();
        for (int p = 0; p < 64; p++) begin
            wait_sck_rise();
            bits[p] = sd_out;
            expected[p] = i2s_bit(bus_left[15:0], bus_right[15:0], p);
        end
        compare("sd_out frame", expected, bits);
        end_test();
    endtask

    task automatic test_missing_halt();
        logic [5:0] frame;
        begin_test("missing_halt");
        frame = 6'($urandom);
        set_ctrl(1'b1, frame);
        for (int i = 0; i < `AE_CODE; i++) begin
            prog[i] = random_word(1'b0);
        end
        write_program(`AE_CODE);
        run_and_check(frame, "no halt");
        end_test();
    endtask

    // Drives sd_in as an I2S source, one bit per sck rise from a frame start
    task automatic send_frames(input int count, input logic [15:0] l, input logic [15:0] r);
        wait_frame_start();
        for (int k = 0; k < count * 64; k++) begin
            wait_sck_rise();
            sd_in = i2s_bit(l, r, k % 64);
        end
        sd_in = 1'b0;
    endtask

    task automatic test_i2s_capture();
        logic [31:0] value;
        logic [31:0] status;
        logic [31:0] fc0;
        logic [31:0] fc1;
        logic        halted;
        int          starts0;
        int          starts1;
        begin_test("i2s_capture");
        value = $urandom;
        prog[0] = mac_word(1'b0, 6'd0, 16'h4000);
        prog[1] = out_word(1'b0);
        prog[2] = mac_word(1'b1, 6'd0, 16'h4000);
        prog[3] = out_word(1'b1);
        prog[4] = 32'd0;
        write_program(5);
        set_ctrl(1'b0, 6'd0);
        wait_frame_start();
        bus_read(reg_addr(`AE_OFS_STATUS, 1), fc0);
        starts0 = frame_starts;
        send_frames(3, value[15:0], value[31:16]);
        // Let the capture of the last frame start its run
        wait_frame_start();
        wait_sck_rise();
        wait_sck_rise();
        wait_done(status);
        bus_read(reg_addr(`AE_OFS_STATUS, 1), fc1);
        starts1 = frame_starts;
        audio_mem[{1'b0, fc1[5:0]}] = value[15:0];
        audio_mem[{1'b1, fc1[5:0]}] = value[31:16];
        run_model(fc1[5:0], halted);
        compare("status", 64'({30'd0, !halted, 1'b1}), 64'(status));
        bus_read(reg_addr(`AE_OFS_RESULT, 0), value);
        compare("left", 64'(model_left), 64'(value));
        bus_read(reg_addr(`AE_OFS_RESULT, 1), value);
        compare("right", 64'(model_right), 64'(value));
        compare("frame counter", 64'(6'(fc0[5:0] - 6'(starts1 - starts0))), 64'(fc1));
        end_test();
    endtask

    initial begin
        rst_n = 1'b0;
        sd_in = 1'b0;
        bus = '0;
        ctrl_shadow = '0;
        model_left = '0;
        model_right = '0;
        sck_q = 1'b0;
        ws_q = 1'b0;
        sck_rose = 1'b0;
        ws_fell = 1'b0;
        frame_starts = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        test_name = "setup";
        seed = $urandom(32'h2ad5_7ec7);
        repeat (4) tick();
        rst_n = 1'b1;
        test_reset_state();
        test_host_program();
        test_i2s_output();
        test_missing_halt();
        test_i2s_capture();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
+incdir+test
logic/audio_pkg.sv
logic/dpram.sv
logic/i2s_clock.sv
logic/i2s_rx.sv
logic/i2s_tx.sv
logic/frame_capture.sv
logic/sequencer.sv
logic/host_regs.sv
logic/audio_engine.sv
test/tb_audio_engine.sv

/* Makefile */
# Verilator simulation of the audio engine testbench

TOP := tb_audio_engine

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
